// File: hw/rvvi_bridge_consts.svh
/* Sizes and encodings for the single-hart RV32 trace bridge.
   Only six machine CSRs are captured; the queue depth must cover all
   outstanding data-bus accesses. */
`ifndef RVVI_BRIDGE_CONSTS_SVH
`define RVVI_BRIDGE_CONSTS_SVH

// Datapath widths
`define RVVI_XLEN      32
`define RVVI_NREG      32
`define RVVI_REG_AW    5
`define RVVI_ILEN      32
`define RVVI_ORDER_W   64

// Captured CSR set
`define RVVI_NCSR      6
`define RVVI_CSR_AW    12

// Machine CSR addresses, same order as the CSR index enum
`define RVVI_CSR_MSTATUS   `RVVI_CSR_AW'('h300)
`define RVVI_CSR_MIE       `RVVI_CSR_AW'('h304)
`define RVVI_CSR_MTVEC     `RVVI_CSR_AW'('h305)
`define RVVI_CSR_MSCRATCH  `RVVI_CSR_AW'('h340)
`define RVVI_CSR_MEPC      `RVVI_CSR_AW'('h341)
`define RVVI_CSR_MCAUSE    `RVVI_CSR_AW'('h342)

// NMI causes for data-bus errors
`define RVVI_NMI_LOAD      32'd1024
`define RVVI_NMI_STORE     32'd1025

// Event tracking
`define RVVI_LSQ_DEPTH     4
`define RVVI_HALT_HOLD     5

`endif

// File: hw/rvfi_pkg.sv
/* Types on the core side of the bridge: one retirement record per cycle
   and one write port per captured CSR. */

`include "rvvi_bridge_consts.svh"

package rvfi_pkg;

   // Index into the captured CSR array
   typedef enum logic [2:0] {
      CSR_MSTATUS  = 3'd0,
      CSR_MIE      = 3'd1,
      CSR_MTVEC    = 3'd2,
      CSR_MSCRATCH = 3'd3,
      CSR_MEPC     = 3'd4,
      CSR_MCAUSE   = 3'd5
   } rvfi_csr_idx_e;

   // One CSR write port
   typedef struct packed {
      logic [`RVVI_XLEN-1:0] wdata;
      logic [`RVVI_XLEN-1:0] wmask;   // Bits written this retirement
   } rvfi_csr_t;

   // Retirement record as the core reports it
   typedef struct packed {
      logic                     valid;
      logic [`RVVI_ORDER_W-1:0] order;
      logic [`RVVI_ILEN-1:0]    insn;
      logic                     trap;
      logic [1:0]               mode;
      logic [`RVVI_XLEN-1:0]    pc_rdata;
      logic [`RVVI_XLEN-1:0]    pc_wdata;
      logic [`RVVI_REG_AW-1:0]  rd_addr;
      logic [`RVVI_XLEN-1:0]    rd_wdata;
   } rvfi_retire_t;

endpackage

// File: hw/rvvi_pkg.sv
/* Types on the comparison-tool side: the registered trace record,
   register and CSR write-back, and the NMI event. */

`include "rvvi_bridge_consts.svh"

package rvvi_pkg;

   // Trace record, zero when nothing retired
   typedef struct packed {
      logic                     valid;
      logic [`RVVI_ORDER_W-1:0] order;
      logic [`RVVI_ILEN-1:0]    insn;
      logic                     trap;
      logic [1:0]               mode;
      logic [`RVVI_XLEN-1:0]    pc_rdata;
      logic [`RVVI_XLEN-1:0]    pc_wdata;
   } rvvi_trace_t;

   // GPR write-back, one-hot over the register file
   typedef struct packed {
      logic [`RVVI_NREG-1:0] x_wb;
      logic [`RVVI_XLEN-1:0] x_wdata;
   } rvvi_xreg_t;

   // One CSR trace entry
   typedef struct packed {
      logic                  wb;
      logic [`RVVI_XLEN-1:0] value;
   } rvvi_csr_trace_t;

   // Non-maskable interrupt with its cause
   typedef struct packed {
      logic                  nmi;
      logic [`RVVI_XLEN-1:0] cause;
   } rvvi_nmi_t;

endpackage

// File: hw/retire_decode.sv
/* Purely combinational. Register 0 never shows a write-back, and every
   output is zero while the retirement is not valid. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module retire_decode (
   input  rvfi_pkg::rvfi_retire_t    retire_i,
   input  rvfi_pkg::rvfi_csr_t       csr_i [`RVVI_NCSR],
   output rvvi_pkg::rvvi_trace_t     trace_o,
   output rvvi_pkg::rvvi_xreg_t      xreg_o,
   output rvvi_pkg::rvvi_csr_trace_t csr_o [`RVVI_NCSR]
);

   //////////////////////////////////////////////////////////////////////
   // Retirement record

   always_comb begin
      trace_o = '0;
      if (retire_i.valid) begin
         trace_o.valid    = 1'b1;
         trace_o.order    = retire_i.order;
         trace_o.insn     = retire_i.insn;
         trace_o.trap     = retire_i.trap;
         trace_o.mode     = retire_i.mode;
         // PC of this instruction and of the next one
         trace_o.pc_rdata = retire_i.pc_rdata;
         trace_o.pc_wdata = retire_i.pc_wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // GPR write-back

   logic rd_write;

   // x0 is hardwired, so a write to it is not reported
   assign rd_write = retire_i.valid && (retire_i.rd_addr != '0);

   always_comb begin
      xreg_o = '0;
      if (rd_write) begin
         xreg_o.x_wb    = `RVVI_NREG'(1) << retire_i.rd_addr;
         xreg_o.x_wdata = retire_i.rd_wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // CSR capture

   always_comb begin
      rvfi_pkg::rvfi_csr_idx_e idx;
      for (int i = 0; i < `RVVI_NCSR; i++) begin
         idx = rvfi_pkg::rvfi_csr_idx_e'(i);
         csr_o[idx] = '0;
         if (retire_i.valid) begin
            // Written when any mask bit is set
            csr_o[idx].wb    = |csr_i[idx].wmask;
            // Only the written bits carry a value
            csr_o[idx].value = csr_i[idx].wdata & csr_i[idx].wmask;
         end
      end
   end

endmodule

// File: hw/hart_event_tracker.sv
/* Tracks outstanding data-bus accesses for the NMI cause and stretches
   the debug halt request. A push into a full queue without a pop is lost. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module hart_event_tracker (
   input  logic                rvvi,
   input  logic                reset_i,
   input  logic                data_req_i,
   input  logic                data_we_i,
   input  logic                data_rvalid_i,
   input  logic                data_err_i,
   input  logic                debug_req_i,
   output rvvi_pkg::rvvi_nmi_t nmi_o,
   output logic                haltreq_o,
   output logic                lsq_underflow_o
);

   localparam int PTR_W  = $clog2(`RVVI_LSQ_DEPTH);
   localparam int CNT_W  = $clog2(`RVVI_LSQ_DEPTH + 1);
   localparam int HOLD_W = $clog2(`RVVI_HALT_HOLD + 1);

   //////////////////////////////////////////////////////////////////////
   // Load/store direction queue

   // One bit per access, 1 for a store
   logic [`RVVI_LSQ_DEPTH-1:0] lsq_mem;
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]           count;

   logic do_pop;
   logic do_push;
   logic underflow;
   logic pop_is_store;

   // Response with nothing outstanding pops nothing
   assign underflow    = data_rvalid_i && (count == '0);
   assign do_pop       = data_rvalid_i && (count != '0);
   // Full queue still accepts a push when a pop frees a slot
   assign do_push      = data_req_i && ((count != CNT_W'(`RVVI_LSQ_DEPTH)) || do_pop);
   assign pop_is_store = lsq_mem[rd_ptr];

   always_ff @(posedge rvvi) begin
      if (do_push) begin
         lsq_mem[wr_ptr] <= data_we_i;
      end
   end

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`RVVI_LSQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`RVVI_LSQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // NMI and underflow pulses

   logic                  nmi_q;
   logic [`RVVI_XLEN-1:0] cause_q;
   logic                  underflow_q;

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         nmi_q       <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         // Single-cycle pulses, one cycle after the response
         nmi_q       <= do_pop && data_err_i;
         underflow_q <= underflow;
      end
   end

   // Cause follows the direction of the access being retired
   always_ff @(posedge rvvi) begin
      if (do_pop) begin
         cause_q <= pop_is_store ? `RVVI_NMI_STORE : `RVVI_NMI_LOAD;
      end
   end

   assign nmi_o.nmi       = nmi_q;
   assign nmi_o.cause     = cause_q;
   assign lsq_underflow_o = underflow_q;

   //////////////////////////////////////////////////////////////////////
   // Debug halt stretch

   logic [HOLD_W-1:0] hold_cnt;

   // Loaded with HOLD-1 since the flop already adds the first cycle
   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         hold_cnt  <= '0;
         haltreq_o <= 1'b0;
      end else begin
         haltreq_o <= debug_req_i || (hold_cnt != '0);
         if (debug_req_i) begin
            hold_cnt <= HOLD_W'(`RVVI_HALT_HOLD - 1);
         end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
         end
      end
   end

endmodule

// File: hw/trace_result.sv
/* Output register stage for the trace path. Accepts a new record every
   cycle; all trace outputs change on the same edge. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module trace_result (
   input  logic                      rvvi,
   input  logic                      reset_i,
   input  rvvi_pkg::rvvi_trace_t     trace_i,
   input  rvvi_pkg::rvvi_xreg_t      xreg_i,
   input  rvvi_pkg::rvvi_csr_trace_t csr_i [`RVVI_NCSR],
   output rvvi_pkg::rvvi_trace_t     trace_o,
   output rvvi_pkg::rvvi_xreg_t      xreg_o,
   output rvvi_pkg::rvvi_csr_trace_t csr_o [`RVVI_NCSR]
);

   //////////////////////////////////////////////////////////////////////
   // Record and GPR stage

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         trace_o <= '0;
         xreg_o  <= '0;
      end else begin
         // Decode already zeroes idle cycles
         trace_o <= trace_i;
         xreg_o  <= xreg_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // CSR stage

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         csr_o <= '{default: '0};
      end else begin
         // Same edge as the record so the tool sees one consistent cycle
         for (int i = 0; i < `RVVI_NCSR; i++) begin
            csr_o[i] <= csr_i[i];
         end
      end
   end

endmodule

// File: hw/rvvi_bridge.sv
/* Trace bridge for one RISC-V hart. Trace outputs lag the retirement by
   one cycle; inputs have no back-pressure and are taken when presented. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module rvvi_bridge (
   input  logic                      rvvi,
   input  logic                      reset_i,
   input  rvfi_pkg::rvfi_retire_t    retire_i,
   input  rvfi_pkg::rvfi_csr_t       csr_i [`RVVI_NCSR],
   input  logic                      data_req_i,
   input  logic                      data_we_i,
   input  logic                      data_rvalid_i,
   input  logic                      data_err_i,
   input  logic                      debug_req_i,
   output rvvi_pkg::rvvi_trace_t     trace_o,
   output rvvi_pkg::rvvi_xreg_t      xreg_o,
   output rvvi_pkg::rvvi_csr_trace_t csr_o [`RVVI_NCSR],
   output rvvi_pkg::rvvi_nmi_t       nmi_o,
   output logic                      haltreq_o,
   output logic                      lsq_underflow_o
);

   //////////////////////////////////////////////////////////////////////
   // Decode to result, combinational

   rvvi_pkg::rvvi_trace_t     dec_trace;
   rvvi_pkg::rvvi_xreg_t      dec_xreg;
   rvvi_pkg::rvvi_csr_trace_t dec_csr [`RVVI_NCSR];

   retire_decode u_decode (
      .retire_i (retire_i),
      .csr_i    (csr_i),
      .trace_o  (dec_trace),
      .xreg_o   (dec_xreg),
      .csr_o    (dec_csr)
   );

   trace_result u_result (
      .rvvi    (rvvi),
      .reset_i (reset_i),
      .trace_i (dec_trace),
      .xreg_i  (dec_xreg),
      .csr_i   (dec_csr),
      .trace_o (trace_o),
      .xreg_o  (xreg_o),
      .csr_o   (csr_o)
   );

   //////////////////////////////////////////////////////////////////////
   // Asynchronous events

   // Bus and debug signals go straight to the tracker
   hart_event_tracker u_events (
      .rvvi            (rvvi),
      .reset_i         (reset_i),
      .data_req_i      (data_req_i),
      .data_we_i       (data_we_i),
      .data_rvalid_i   (data_rvalid_i),
      .data_err_i      (data_err_i),
      .debug_req_i     (debug_req_i),
      .nmi_o           (nmi_o),
      .haltreq_o       (haltreq_o),
      .lsq_underflow_o (lsq_underflow_o)
   );

endmodule

// File: verif/rvvi_bridge_checker.sv
/* Samples the bridge on the falling clock edge, where inputs and outputs
   are both stable. Checking starts after the first reset cycle. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module rvvi_bridge_checker (
   input  logic                      rvvi,
   input  logic                      reset_i,
   input  logic [127:0]              test_name_i,
   input  logic [1:0]                exp_evt_i,
   input  rvfi_pkg::rvfi_retire_t    retire_i,
   input  rvfi_pkg::rvfi_csr_t       csr_wr_i [`RVVI_NCSR],
   input  logic                      data_req_i,
   input  logic                      data_we_i,
   input  logic                      data_rvalid_i,
   input  logic                      data_err_i,
   input  logic                      debug_req_i,
   input  rvvi_pkg::rvvi_trace_t     trace_i,
   input  rvvi_pkg::rvvi_xreg_t      xreg_i,
   input  rvvi_pkg::rvvi_csr_trace_t csr_trace_i [`RVVI_NCSR],
   input  rvvi_pkg::rvvi_nmi_t       nmi_i,
   input  logic                      haltreq_i,
   input  logic                      lsq_underflow_i,
   output logic                      armed_o,
   output int                        check_count_o,
   output int                        error_count_o
);

   //////////////////////////////////////////////////////////////////////
   // Expected outputs for the next cycle

   rvvi_pkg::rvvi_trace_t     exp_trace;
   rvvi_pkg::rvvi_xreg_t      exp_xreg;
   rvvi_pkg::rvvi_csr_trace_t exp_csr [`RVVI_NCSR];
   logic                      exp_wdata_known;
   logic                      exp_nmi;
   logic [`RVVI_XLEN-1:0]     exp_cause;
   logic                      exp_uflow;
   logic                      exp_halt;
   logic [1:0]                exp_evt;
   logic [127:0]              exp_name;
   logic                      exp_ready = 1'b0;
   logic                      armed = 1'b0;

   // Reference queue of access directions, 1 for a store
   bit   lsq [$];
   int   cycle = 0;
   int   last_req = 0;
   logic req_seen = 1'b0;
   int   checks = 0;
   int   errors = 0;

   assign armed_o       = armed;
   assign check_count_o = checks;
   assign error_count_o = errors;

   task automatic check_value(input string what, input logic [255:0] exp,
                              input logic [255:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("error %0s %0s: expected %0h actual %0h", exp_name, what, exp, act);
      end
   endtask

   always @(negedge rvvi) begin
      bit is_store;
      // Compare what the previous cycle promised
      if (exp_ready) begin
         check_value("trace", exp_trace, trace_i);
         check_value("x_wb", exp_xreg.x_wb, xreg_i.x_wb);
         if (exp_wdata_known) begin
            check_value("x_wdata", exp_xreg.x_wdata, xreg_i.x_wdata);
         end
         for (int i = 0; i < `RVVI_NCSR; i++) begin
            check_value($sformatf("csr%0d", i), exp_csr[i], csr_trace_i[i]);
         end
         check_value("nmi", exp_nmi, nmi_i.nmi);
         if (exp_nmi) begin
            check_value("nmi cause", exp_cause, nmi_i.cause);
         end
         check_value("underflow", exp_uflow, lsq_underflow_i);
         check_value("haltreq", exp_halt, haltreq_i);
         // Event column of the stimulus table
         check_value("table nmi", (exp_evt == 2'd1) || (exp_evt == 2'd2), nmi_i.nmi);
         check_value("table underflow", exp_evt == 2'd3, lsq_underflow_i);
         if (exp_evt == 2'd1 || exp_evt == 2'd2) begin
            check_value("table cause", (exp_evt == 2'd2) ? `RVVI_NMI_STORE : `RVVI_NMI_LOAD,
                        nmi_i.cause);
         end
      end

      exp_name = test_name_i;
      exp_evt  = exp_evt_i;
      cycle++;
      exp_trace       = '0;
      exp_xreg        = '0;
      exp_wdata_known = 1'b1;
      exp_nmi         = 1'b0;
      exp_uflow       = 1'b0;
      for (int i = 0; i < `RVVI_NCSR; i++) begin
         exp_csr[i] = '0;
      end

      if (reset_i) begin
         lsq.delete();
         req_seen  = 1'b0;
         exp_halt  = 1'b0;
         exp_ready = 1'b1;
      end else begin
         armed = exp_ready;
         // Retirement record and GPR write-back
         if (retire_i.valid) begin
            exp_trace.valid    = 1'b1;
            exp_trace.order    = retire_i.order;
            exp_trace.insn     = retire_i.insn;
            exp_trace.trap     = retire_i.trap;
            exp_trace.mode     = retire_i.mode;
            exp_trace.pc_rdata = retire_i.pc_rdata;
            exp_trace.pc_wdata = retire_i.pc_wdata;
            if (retire_i.rd_addr != 0) begin
               exp_xreg.x_wb[retire_i.rd_addr] = 1'b1;
               exp_xreg.x_wdata                = retire_i.rd_wdata;
            end else begin
               // x0 shows only an empty mask
               exp_wdata_known = 1'b0;
            end
            for (int i = 0; i < `RVVI_NCSR; i++) begin
               exp_csr[i].wb    = (csr_wr_i[i].wmask != 0);
               exp_csr[i].value = csr_wr_i[i].wdata & csr_wr_i[i].wmask;
            end
         end
         // Responses retire the oldest access first
         if (data_rvalid_i) begin
            if (lsq.size() == 0) begin
               exp_uflow = 1'b1;
            end else begin
               is_store  = lsq.pop_front();
               exp_nmi   = data_err_i;
               exp_cause = is_store ? `RVVI_NMI_STORE : `RVVI_NMI_LOAD;
            end
         end
         if (data_req_i) begin
            lsq.push_back(data_we_i);
         end
         // Halt covers every cycle up to HOLD after the last request
         if (debug_req_i) begin
            req_seen = 1'b1;
            last_req = cycle;
         end
         exp_halt = req_seen && ((cycle - last_req) < `RVVI_HALT_HOLD);
      end
   end

endmodule

// File: verif/rvvi_bridge_tb.sv
/* Drives the bridge from a fixed table with seeded random data fields.
   All comparisons happen in the checker module. */
`timescale 1ns/10ps

`include "rvvi_bridge_consts.svh"

module rvvi_bridge_tb;

   localparam int TIMEOUT = 100;

   // One stimulus row; evt is the expected event in the next cycle
   // 0 none, 1 load NMI, 2 store NMI, 3 underflow
   typedef struct packed {
      logic [127:0]            name;
      logic                    valid;
      logic [`RVVI_REG_AW-1:0] rd;
      logic                    trap;
      logic                    csr_en;
      logic                    req;
      logic                    we;
      logic                    rvalid;
      logic                    err;
      logic                    dbg;
      logic [1:0]              evt;
   } row_t;

   row_t rows [$];

   logic                      rvvi = 1'b0;
   logic                      reset_i;
   logic [127:0]              test_name;
   logic [1:0]                exp_evt;
   rvfi_pkg::rvfi_retire_t    retire;
   rvfi_pkg::rvfi_csr_t       csr_wr [`RVVI_NCSR];
   logic                      data_req;
   logic                      data_we;
   logic                      data_rvalid;
   logic                      data_err;
   logic                      debug_req;
   rvvi_pkg::rvvi_trace_t     trace;
   rvvi_pkg::rvvi_xreg_t      xreg;
   rvvi_pkg::rvvi_csr_trace_t csr_trace [`RVVI_NCSR];
   rvvi_pkg::rvvi_nmi_t       nmi;
   logic                      haltreq;
   logic                      lsq_underflow;
   logic                      armed;
   int                        check_count;
   int                        error_count;

   // 8 ns period
   always #4 rvvi = ~rvvi;

   rvvi_bridge UUT (
      .rvvi (rvvi), .reset_i (reset_i), .retire_i (retire), .csr_i (csr_wr),
      .data_req_i (data_req), .data_we_i (data_we), .data_rvalid_i (data_rvalid),
      .data_err_i (data_err), .debug_req_i (debug_req), .trace_o (trace),
      .xreg_o (xreg), .csr_o (csr_trace), .nmi_o (nmi), .haltreq_o (haltreq),
      .lsq_underflow_o (lsq_underflow)
   );

   rvvi_bridge_checker u_checker (
      .rvvi (rvvi), .reset_i (reset_i), .test_name_i (test_name), .exp_evt_i (exp_evt),
      .retire_i (retire), .csr_wr_i (csr_wr), .data_req_i (data_req),
      .data_we_i (data_we), .data_rvalid_i (data_rvalid), .data_err_i (data_err),
      .debug_req_i (debug_req), .trace_i (trace), .xreg_i (xreg),
      .csr_trace_i (csr_trace), .nmi_i (nmi), .haltreq_i (haltreq),
      .lsq_underflow_i (lsq_underflow), .armed_o (armed),
      .check_count_o (check_count), .error_count_o (error_count)
   );

   task automatic add_row(input logic [127:0] name, input logic valid,
                          input logic [4:0] rd, input logic trap, input logic csr_en,
                          input logic req, input logic we, input logic rvalid,
                          input logic err, input logic dbg, input logic [1:0] evt);
      rows.push_back('{name, valid, rd, trap, csr_en, req, we, rvalid, err, dbg, evt});
   endtask

   // Data fields random, control fields from the row
   task automatic apply_row(input row_t r);
      rvfi_pkg::rvfi_retire_t ret;
      rvfi_pkg::rvfi_csr_t    csr_v [`RVVI_NCSR];
      ret.valid    = r.valid;
      ret.order    = {$urandom(), $urandom()};
      ret.insn     = $urandom();
      ret.trap     = r.trap;
      ret.mode     = $urandom_range(3);
      ret.pc_rdata = $urandom();
      ret.pc_wdata = ret.pc_rdata + 4;
      ret.rd_addr  = r.rd;
      ret.rd_wdata = $urandom();
      for (int i = 0; i < `RVVI_NCSR; i++) begin
         csr_v[i].wdata = $urandom();
         csr_v[i].wmask = r.csr_en ? $urandom() : '0;
      end
      @(posedge rvvi);
      test_name   <= r.name;
      exp_evt     <= r.evt;
      retire      <= ret;
      data_req    <= r.req;
      data_we     <= r.we;
      data_rvalid <= r.rvalid;
      data_err    <= r.err;
      debug_req   <= r.dbg;
      for (int i = 0; i < `RVVI_NCSR; i++) begin
         csr_wr[i] <= csr_v[i];
      end
   endtask

   initial begin
      int unsigned seed_val;
      int          n;
      row_t        idle_row;
      seed_val    = $urandom(32'h88a47d0d);
      reset_i     = 1'b1;
      test_name   = "reset";
      exp_evt     = 2'd0;
      retire      = '0;
      csr_wr      = '{default: '0};
      data_req    = 1'b0;
      data_we     = 1'b0;
      data_rvalid = 1'b0;
      data_err    = 1'b0;
      debug_req   = 1'b0;
      idle_row      = '0;
      idle_row.name = "drain";

      //                name              v  rd     tr cs rq we rv er db ev
      add_row("retire_basic",   1, 5'd5,  0, 1, 0, 0, 0, 0, 0, 2'd0);
      add_row("idle",           0, 5'd3,  0, 1, 0, 0, 0, 0, 0, 2'd0);
      add_row("rd_zero",        1, 5'd0,  1, 1, 0, 0, 0, 0, 0, 2'd0);
      add_row("csr_zero_mask",  1, 5'd31, 0, 0, 0, 0, 0, 0, 0, 2'd0);
      add_row("load_req",       1, 5'd7,  0, 1, 1, 0, 0, 0, 0, 2'd0);
      add_row("store_req",      0, 5'd0,  0, 0, 1, 1, 0, 0, 0, 2'd0);
      add_row("resp_ok",        1, 5'd12, 0, 1, 0, 0, 1, 0, 0, 2'd0);
      add_row("resp_err_store", 1, 5'd9,  0, 1, 0, 0, 1, 1, 0, 2'd2);
      add_row("store_req2",     1, 5'd1,  0, 1, 1, 1, 0, 0, 0, 2'd0);
      add_row("load_req2",      0, 5'd0,  0, 0, 1, 0, 0, 0, 0, 2'd0);
      add_row("resp_ok2",       1, 5'd20, 1, 1, 0, 0, 1, 0, 0, 2'd0);
      add_row("resp_err_load",  0, 5'd0,  0, 0, 0, 0, 1, 1, 0, 2'd1);
      add_row("underflow",      1, 5'd15, 0, 1, 0, 0, 1, 1, 0, 2'd3);
      add_row("debug_req",      0, 5'd0,  0, 0, 0, 0, 0, 0, 1, 2'd0);
      add_row("debug_req",      1, 5'd2,  0, 1, 0, 0, 0, 0, 1, 2'd0);
      add_row("debug_req",      0, 5'd0,  0, 0, 0, 0, 0, 0, 1, 2'd0);

      repeat (10) @(posedge rvvi);
      reset_i <= 1'b0;

      // Checker arms once it has seen reset drop
      n = 0;
      while (!armed && n < TIMEOUT) begin
         @(posedge rvvi);
         n++;
      end
      if (!armed) begin
         $display("timeout: the checker never saw reset released");
         $display("Checks failed");
         $finish;
      end

      foreach (rows[i]) begin
         apply_row(rows[i]);
      end

      // Idle until the halt stretch has run out
      n = 0;
      apply_row(idle_row);
      @(negedge rvvi);
      while (haltreq && n < TIMEOUT) begin
         apply_row(idle_row);
         @(negedge rvvi);
         n++;
      end
      if (haltreq) begin
         $display("timeout: haltreq_o stayed high after the table ended");
         $display("Checks failed");
         $finish;
      end

      // Last idle row still needs its one-cycle compare
      apply_row(idle_row);
      @(negedge rvvi);
      @(posedge rvvi);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: rvvi_bridge.f
+incdir+hw
hw/rvfi_pkg.sv
hw/rvvi_pkg.sv
hw/retire_decode.sv
hw/hart_event_tracker.sv
hw/trace_result.sv
hw/rvvi_bridge.sv
verif/rvvi_bridge_checker.sv
verif/rvvi_bridge_tb.sv
